/* files.f */
+incdir+common
+incdir+verification
common/isa_pkg.sv
common/core_pkg.sv
hw/regfile.sv
hw/alu.sv
hw/decoder.sv
hw/fetch_unit.sv
hw/core_ctrl.sv
hw/core_top.sv
verification/tb_core.sv

/* Makefile */
# Verilator build and run of the RV32E core testbench.

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// **************************************************
// stimulus LFSR.
// **************************************************

// galois form of x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	int          i;
	v = '0;
	for (i = 0; i < n; i++) begin
		v    = {v[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
	end
	return v;
endfunction

// **************************************************
// instruction model.
// **************************************************

function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
	case (f3)
		3'b000: return alt ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
		3'b011: return (a < b) ? `XLEN'(1) : `XLEN'(0);
		3'b100: return a ^ b;
		3'b101: begin
			if (alt) begin
				return $signed(a) >>> b[4:0];
			end
			return a >> b[4:0];
		end
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

// runs one instruction on model_regs and model_pc; an illegal one changes nothing.
function automatic void ref_step(input logic [31:0] inst, output logic bad,
		output logic [`XLEN-1:0] pc_o, output logic [`REG_AW-1:0] rd_o,
		output logic [`XLEN-1:0] data_o);
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] wb;
	logic [`XLEN-1:0] next_pc;
	logic [2:0]       f3;
	logic             wr;
	logic             go;
	f3      = inst[14:12];
	a       = model_regs[inst[18:15]];
	b       = model_regs[inst[23:20]];
	imm_i   = {{20{inst[31]}}, inst[31:20]};
	next_pc = model_pc + `XLEN'(4);
	wb      = '0;
	wr      = 1'b1;
	go      = 1'b0;
	bad     = inst[11];
	case (inst[6:0])
		OP: begin
			wb  = alu_ref(f3, inst[30], a, b);
			bad = bad || inst[19] || inst[24];
		end
		OP_IMM: begin
			wb  = alu_ref(f3, f3 == 3'b101 && inst[30], a, imm_i);
			bad = bad || inst[19];
		end
		LUI: wb = {inst[31:12], 12'b0};
		AUIPC: wb = model_pc + {inst[31:12], 12'b0};
		JAL: begin
			wb      = next_pc;
			next_pc = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		end
		JALR: begin
			wb      = next_pc;
			next_pc = (a + imm_i) & ~`XLEN'(1);
			bad     = bad || inst[19] || f3 != 3'b000;
		end
		BRANCH: begin
			wr  = 1'b0;
			bad = inst[19] || inst[24] || f3[2:1] == 2'b01;
			case (f3)
				3'b000:  go = (a == b);
				3'b001:  go = (a != b);
				3'b100:  go = ($signed(a) < $signed(b));
				3'b101:  go = ($signed(a) >= $signed(b));
				3'b110:  go = (a < b);
				default: go = (a >= b);
			endcase
			if (go) begin
				next_pc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
		end
		default: bad = 1'b1;
	endcase
	pc_o   = model_pc;
	rd_o   = '0;
	data_o = '0;
	if (!bad) begin
		if (wr && inst[10:7] != 4'd0) begin
			model_regs[inst[10:7]] = wb;
			rd_o   = inst[10:7];
			data_o = wb;
		end
		model_pc = next_pc;
	end
endfunction

`endif

/* verification/tb_core.sv */
`include "rv_defs.svh"

module tb_core import isa_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMEM_WORDS     = 64;
	localparam int IMEM_AW        = 6;
	localparam int N_RAND         = 40;
	localparam int MEM_DELAY_MAX  = 8;
	localparam int CREDIT_GAP_MAX = 64;
	localparam int TAIL_CYCLES    = 20;

	logic               clock;
	logic               rst;
	logic               fetch_credit;
	logic               fetch_req;
	logic [`XLEN-1:0]   fetch_addr;
	logic               fetch_rsp_valid;
	logic [`XLEN-1:0]   fetch_rsp_inst;
	logic               retire_valid;
	logic [`XLEN-1:0]   retire_pc;
	logic [`REG_AW-1:0] retire_rd;
	logic [`XLEN-1:0]   retire_data;
	logic               trap;

	logic [31:0]        lfsr;
	logic [`XLEN-1:0]   model_pc;
	logic [`XLEN-1:0]   model_regs [`REG_COUNT];
	logic [31:0]        imem [IMEM_WORDS];
	logic [`XLEN-1:0]   rsp_addr;
	logic [`XLEN-1:0]   ill_addr;
	logic               trap_seen;
	logic               rsp_prev;
	logic               bad;
	logic [`XLEN-1:0]   exp_pc;
	logic [`REG_AW-1:0] exp_rd;
	logic [`XLEN-1:0]   exp_data;
	int                 prog_len;
	int                 exp_retires;
	int                 retired;
	int                 fetches;
	int                 cycles;
	int                 timeout_limit;
	int                 tb_credits;
	int                 rsp_wait;
	int                 credit_gap;

	`include "tb_ref_model.svh"

	core_top dut (
		.clock           (clock),
		.rst             (rst),
		.fetch_credit    (fetch_credit),
		.fetch_req       (fetch_req),
		.fetch_addr      (fetch_addr),
		.fetch_rsp_valid (fetch_rsp_valid),
		.fetch_rsp_inst  (fetch_rsp_inst),
		.retire_valid    (retire_valid),
		.retire_pc       (retire_pc),
		.retire_rd       (retire_rd),
		.retire_data     (retire_data),
		.trap            (trap)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	// **************************************************
	// checks.
	// **************************************************

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [`XLEN-1:0] exp_v,
			input logic [`XLEN-1:0] act_v);
		if (exp_v !== act_v) begin
			fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp_v, act_v));
		end
	endtask

	task automatic check_reg(input string name, input logic [`REG_AW-1:0] exp_v,
			input logic [`REG_AW-1:0] act_v);
		if (exp_v !== act_v) begin
			fail_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp_v, act_v));
		end
	endtask

	// **************************************************
	// program and memory side.
	// **************************************************

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [3:0] rs2,
			input logic [3:0] rs1, input logic [2:0] f3, input logic [3:0] rd,
			input logic [6:0] op);
		return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, op};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [3:0] rs1,
			input logic [2:0] f3, input logic [3:0] rd, input logic [6:0] op);
		return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] off, input logic [3:0] rs2,
			input logic [3:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, f3, off[4:1], off[11], BRANCH};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [3:0] rd,
			input logic [6:0] op);
		return {imm, 1'b0, rd, op};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] off, input logic [3:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], 1'b0, rd, JAL};
	endfunction

	task automatic emit(input logic [31:0] inst, input logic runs);
		imem[prog_len] = inst;
		prog_len++;
		if (runs) begin
			exp_retires++;
		end
	endtask

	task automatic build_program();
		logic [2:0]  f3;
		logic [3:0]  rd;
		logic [3:0]  rs1;
		logic [3:0]  rs2;
		logic [11:0] imm;
		logic        alt;
		int          i;
		// unused words carry opcode 0, which traps.
		for (i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = (i * 32'h9e37_79b1) & ~32'h7f;
		end
		for (i = 0; i < N_RAND; i++) begin
			f3  = 3'(rand_bits(3));
			rd  = 4'(rand_bits(4));
			rs1 = 4'(rand_bits(4));
			rs2 = 4'(rand_bits(4));
			case (rand_bits(2))
				0: begin
					alt = (f3 == 3'b000 || f3 == 3'b101) && rand_bits(1) != 0;
					emit(r_word({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OP), 1'b1);
				end
				1: begin
					imm = 12'(rand_bits(12));
					if (f3 == 3'b001) begin
						imm[11:5] = 7'b0;
					end else if (f3 == 3'b101) begin
						imm[11:5] = {1'b0, imm[10], 5'b0};
					end
					emit(i_word(imm, rs1, f3, rd, OP_IMM), 1'b1);
				end
				2: emit(u_word(20'(rand_bits(20)), rd, LUI), 1'b1);
				default: emit(u_word(20'(rand_bits(20)), rd, AUIPC), 1'b1);
			endcase
		end
		// x1 = x2 = 5, a write to x0, then a read of x0.
		emit(i_word(12'd5, 4'd0, 3'b000, 4'd1, OP_IMM), 1'b1);
		emit(i_word(12'd5, 4'd0, 3'b000, 4'd2, OP_IMM), 1'b1);
		emit(i_word(12'd7, 4'd1, 3'b000, 4'd0, OP_IMM), 1'b1);
		emit(r_word(7'd0, 4'd1, 4'd0, 3'b000, 4'd3, OP), 1'b1);
		// beq taken, bne not, blt taken, bge not, bgeu taken
		emit(b_word(13'd8, 4'd2, 4'd1, 3'b000), 1'b1);
		emit(i_word(12'd1, 4'd0, 3'b000, 4'd4, OP_IMM), 1'b0);
		emit(b_word(13'd8, 4'd2, 4'd1, 3'b001), 1'b1);
		emit(b_word(13'd8, 4'd1, 4'd0, 3'b100), 1'b1);
		emit(i_word(12'd2, 4'd0, 3'b000, 4'd4, OP_IMM), 1'b0);
		emit(b_word(13'd8, 4'd1, 4'd0, 3'b101), 1'b1);
		emit(b_word(13'd8, 4'd2, 4'd1, 3'b111), 1'b1);
		emit(i_word(12'd3, 4'd0, 3'b000, 4'd4, OP_IMM), 1'b0);
		emit(j_word(21'd8, 4'd5), 1'b1);
		emit(i_word(12'd4, 4'd0, 3'b000, 4'd4, OP_IMM), 1'b0);
		// jalr with an odd offset drops bit 0 of the target.
		emit(u_word(20'd0, 4'd6, AUIPC), 1'b1);
		emit(i_word(12'd13, 4'd6, 3'b000, 4'd7, JALR), 1'b1);
		emit(i_word(12'd5, 4'd0, 3'b000, 4'd4, OP_IMM), 1'b0);
		emit(i_word(12'd9, 4'd4, 3'b000, 4'd4, OP_IMM), 1'b1);
		ill_addr = `XLEN'(prog_len * 4);
		emit(32'hffff_ffff, 1'b0);
	endtask

	task automatic drive_inputs();
		fetch_rsp_valid = 1'b0;
		fetch_credit    = 1'b0;
		if (rsp_wait != 0) begin
			rsp_wait--;
			if (rsp_wait == 0) begin
				fetch_rsp_valid = 1'b1;
				fetch_rsp_inst  = imem[rsp_addr[IMEM_AW+1:2]];
			end
		end
		// mostly short gaps with long dry spells now and then.
		if (credit_gap != 0) begin
			credit_gap--;
		end else if (tb_credits < `CREDIT_MAX) begin
			fetch_credit = 1'b1;
			if (rand_bits(3) == 0) begin
				credit_gap = 32 + int'(rand_bits(5));
			end else begin
				credit_gap = int'(rand_bits(2));
			end
		end
	endtask

	// **************************************************
	// stimulus and end of run.
	// **************************************************

	initial begin
		int tail;
		rst             = 1'b1;
		fetch_credit    = 1'b0;
		fetch_rsp_valid = 1'b0;
		fetch_rsp_inst  = '0;
		lfsr            = 32'hf088;
		model_pc        = `RESET_PC;
		trap_seen       = 1'b0;
		rsp_prev        = 1'b0;
		prog_len        = 0;
		exp_retires     = 0;
		retired         = 0;
		fetches         = 0;
		cycles          = 0;
		tb_credits      = 0;
		rsp_wait        = 0;
		credit_gap      = 0;
		tail            = 0;
		for (int r = 0; r < `REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		build_program();
		timeout_limit = prog_len * (MEM_DELAY_MAX + CREDIT_GAP_MAX + 4);
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		while (!trap_seen || tail < TAIL_CYCLES) begin
			@(negedge clock);
			drive_inputs();
			if (trap_seen) begin
				tail++;
			end
		end
		if (retired != exp_retires) begin
			fail_run($sformatf("%0d instructions retired where %0d were expected",
				retired, exp_retires));
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

	// the compare process samples the DUT on the rising edge.
	always @(posedge clock) begin
		if (!rst) begin
			cycles++;
			if (cycles > timeout_limit) begin
				fail_run("the core did not reach the trap within the cycle limit");
			end
			if (rsp_prev != (retire_valid || (trap && !trap_seen))) begin
				fail_run("retire or trap did not follow the fetch response by one cycle");
			end
			if (fetch_req) begin
				if (trap_seen) begin
					fail_run("a fetch request was issued after the trap");
				end
				if (tb_credits == 0) begin
					fail_run("a fetch request was issued while no credit was held");
				end
				check_word($sformatf("fetch %0d addr", fetches), model_pc, fetch_addr);
				fetches++;
				rsp_addr = fetch_addr;
				rsp_wait = 1 + int'(rand_bits(3));
			end
			tb_credits = tb_credits + int'(fetch_credit) - int'(fetch_req);
			if (retire_valid) begin
				if (trap || trap_seen) begin
					fail_run("an instruction retired together with the trap");
				end
				ref_step(imem[model_pc[IMEM_AW+1:2]], bad, exp_pc, exp_rd, exp_data);
				if (bad) begin
					fail_run("the core retired an illegal instruction");
				end
				check_word($sformatf("inst %0d retire_pc", retired), exp_pc, retire_pc);
				check_reg($sformatf("inst %0d retire_rd", retired), exp_rd, retire_rd);
				check_word($sformatf("inst %0d retire_data", retired), exp_data, retire_data);
				retired++;
			end
			if (trap_seen && !trap) begin
				fail_run("the trap dropped after it had been raised");
			end
			if (trap && !trap_seen) begin
				ref_step(imem[model_pc[IMEM_AW+1:2]], bad, exp_pc, exp_rd, exp_data);
				if (!bad) begin
					fail_run("the core trapped on a legal instruction");
				end
				check_word("trap pc", ill_addr, retire_pc);
				trap_seen = 1'b1;
			end
			rsp_prev = fetch_rsp_valid;
		end
	end

endmodule

/* hw/core_top.sv */
`include "rv_defs.svh"

module core_top import core_pkg::*; (
	input  logic               clock,
	input  logic               rst,
	input  logic               fetch_credit,
	output logic               fetch_req,
	output logic [`XLEN-1:0]   fetch_addr,
	input  logic               fetch_rsp_valid,
	input  logic [`XLEN-1:0]   fetch_rsp_inst,
	output logic               retire_valid,
	output logic [`XLEN-1:0]   retire_pc,
	output logic [`REG_AW-1:0] retire_rd,
	output logic [`XLEN-1:0]   retire_data,
	output logic               trap
);

	logic               have_credit;
	logic               fetch_go;
	logic               ir_load;
	logic               pc_we;
	logic               rf_we;
	logic               illegal;
	logic [`XLEN-1:0]   pc;
	logic [`REG_AW-1:0] rs1;
	logic [`REG_AW-1:0] rs2;
	logic [`REG_AW-1:0] rd;
	logic [`REG_AW-1:0] rd_eff;
	logic [`XLEN-1:0]   imm;
	alu_op_e            alu_op;
	br_cond_e           br_cond;
	logic               a_sel;
	logic               b_sel;
	logic               jump;
	logic               jalr;
	logic               wb_pc4;
	logic               writes_rd;
	logic [`XLEN-1:0]   rs1_data;
	logic [`XLEN-1:0]   rs2_data;
	logic [`XLEN-1:0]   alu_a;
	logic [`XLEN-1:0]   alu_b;
	logic [`XLEN-1:0]   result;
	logic               taken;
	logic [`XLEN-1:0]   wb_data;

	// **************************************************
	// control and fetch.
	// **************************************************

	core_ctrl u_ctrl (
		.clock           (clock),
		.rst             (rst),
		.have_credit     (have_credit),
		.fetch_rsp_valid (fetch_rsp_valid),
		.illegal         (illegal),
		.fetch_go        (fetch_go),
		.ir_load         (ir_load),
		.pc_we           (pc_we),
		.rf_we           (rf_we),
		.retire_valid    (retire_valid),
		.trap            (trap)
	);

	fetch_unit u_fetch (
		.clock        (clock),
		.rst          (rst),
		.fetch_credit (fetch_credit),
		.fetch_go     (fetch_go),
		.pc_we        (pc_we),
		.taken        (taken),
		.jump         (jump),
		.jalr         (jalr),
		.imm          (imm),
		.rs1_data     (rs1_data),
		.pc           (pc),
		.have_credit  (have_credit)
	);

	assign fetch_req  = fetch_go;
	assign fetch_addr = pc;

	// **************************************************
	// decode, execute, write-back.
	// **************************************************

	decoder u_dec (
		.clock          (clock),
		.ir_load        (ir_load),
		.fetch_rsp_inst (fetch_rsp_inst),
		.rs1            (rs1),
		.rs2            (rs2),
		.rd             (rd),
		.imm            (imm),
		.alu_op         (alu_op),
		.br_cond        (br_cond),
		.a_sel          (a_sel),
		.b_sel          (b_sel),
		.jump           (jump),
		.jalr           (jalr),
		.wb_pc4         (wb_pc4),
		.writes_rd      (writes_rd),
		.illegal        (illegal)
	);

	assign alu_a = (a_sel == A_PC) ? pc : rs1_data;
	assign alu_b = (b_sel == B_IMM) ? imm : rs2_data;

	alu u_alu (
		.a        (alu_a),
		.b        (alu_b),
		.alu_op   (alu_op),
		.br_cond  (br_cond),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.result   (result),
		.taken    (taken)
	);

	// rd field of a branch holds offset bits, so mask it.
	assign rd_eff  = writes_rd ? rd : '0;
	assign wb_data = wb_pc4 ? (pc + `XLEN'(4)) : result;

	regfile u_rf (
		.clock  (clock),
		.rst    (rst),
		.we     (rf_we),
		.waddr  (rd_eff),
		.wdata  (wb_data),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	assign retire_pc   = pc;
	assign retire_rd   = rd_eff;
	assign retire_data = (rd_eff != '0) ? wb_data : '0;

endmodule

/* hw/core_ctrl.sv */
module core_ctrl import core_pkg::*; (
	input  logic clock,
	input  logic rst,
	input  logic have_credit,
	input  logic fetch_rsp_valid,
	input  logic illegal,
	output logic fetch_go,
	output logic ir_load,
	output logic pc_we,
	output logic rf_we,
	output logic retire_valid,
	output logic trap
);

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic        exec_ok;

	// **************************************************
	// state machine.
	// **************************************************

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= FETCH;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			FETCH: begin
				if (have_credit) begin
					state_next = WAIT;
				end
			end
			WAIT: begin
				if (fetch_rsp_valid) begin
					state_next = EXEC;
				end
			end
			// lasts a single cycle.
			EXEC: begin
				state_next = illegal ? TRAP : FETCH;
			end
			default: begin
				state_next = TRAP;
			end
		endcase
	end

	// **************************************************
	// control outputs.
	// **************************************************

	assign exec_ok      = (state == EXEC) && !illegal;
	assign fetch_go     = (state == FETCH) && have_credit;
	assign ir_load      = (state == WAIT) && fetch_rsp_valid;
	assign pc_we        = exec_ok;
	assign rf_we        = exec_ok;
	assign retire_valid = exec_ok;

	// raised in the failing EXEC cycle, then held by TRAP.
	assign trap = (state == TRAP) || ((state == EXEC) && illegal);

	a_rsp_in_wait: assert property (@(posedge clock) disable iff (rst)
		fetch_rsp_valid |-> state == WAIT);

	a_state_known: assert property (@(posedge clock) disable iff (rst)
		!$isunknown(state));

endmodule

/* hw/fetch_unit.sv */
`include "rv_defs.svh"

module fetch_unit (
	input  logic             clock,
	input  logic             rst,
	input  logic             fetch_credit,
	input  logic             fetch_go,
	input  logic             pc_we,
	input  logic             taken,
	input  logic             jump,
	input  logic             jalr,
	input  logic [`XLEN-1:0] imm,
	input  logic [`XLEN-1:0] rs1_data,
	output logic [`XLEN-1:0] pc,
	output logic             have_credit
);

	localparam int CREDIT_W = $clog2(`CREDIT_MAX + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_TOP = CREDIT_W'(`CREDIT_MAX);

	logic [CREDIT_W-1:0] credit_cnt;
	logic [`XLEN-1:0]    pc_plus4;
	logic [`XLEN-1:0]    pc_rel;
	logic [`XLEN-1:0]    jalr_tgt;
	logic [`XLEN-1:0]    next_pc;

	// **************************************************
	// program counter.
	// **************************************************

	assign pc_plus4 = pc + `XLEN'(4);
	assign pc_rel   = pc + imm;
	assign jalr_tgt = (rs1_data + imm) & ~`XLEN'(1);
	assign next_pc  = jalr ? jalr_tgt : ((jump || taken) ? pc_rel : pc_plus4);

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= `RESET_PC;
		end else if (pc_we) begin
			pc <= next_pc;
		end
	end

	// **************************************************
	// credit counter.
	// **************************************************

	// a grant and a spend in the same cycle cancel.
	always_ff @(posedge clock) begin
		if (rst) begin
			credit_cnt <= '0;
		end else if (fetch_credit && !fetch_go && credit_cnt != CREDIT_TOP) begin
			credit_cnt <= credit_cnt + 1'b1;
		end else if (fetch_go && !fetch_credit) begin
			credit_cnt <= credit_cnt - 1'b1;
		end
	end

	assign have_credit = (credit_cnt != '0);

	a_credit_cap: assert property (@(posedge clock) disable iff (rst)
		fetch_credit && !fetch_go |-> credit_cnt != CREDIT_TOP);

endmodule

/* hw/decoder.sv */
`include "rv_defs.svh"

module decoder import isa_pkg::*, core_pkg::*; (
	input  logic               clock,
	input  logic               ir_load,
	input  logic [`XLEN-1:0]   fetch_rsp_inst,
	output logic [`REG_AW-1:0] rs1,
	output logic [`REG_AW-1:0] rs2,
	output logic [`REG_AW-1:0] rd,
	output logic [`XLEN-1:0]   imm,
	output alu_op_e            alu_op,
	output br_cond_e           br_cond,
	output logic               a_sel,
	output logic               b_sel,
	output logic               jump,
	output logic               jalr,
	output logic               wb_pc4,
	output logic               writes_rd,
	output logic               illegal
);

	rv_inst_u         ir;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic             uses_rs1;
	logic             uses_rs2;
	logic             bad_op;
	logic             bad_reg;

	function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? SUB : ADD;
			3'b001:  return SLL;
			3'b010:  return SLT;
			3'b011:  return SLTU;
			3'b100:  return XOR;
			3'b101:  return alt ? SRA : SRL;
			3'b110:  return OR;
			default: return AND;
		endcase
	endfunction

	always_ff @(posedge clock) begin
		if (ir_load) begin
			ir <= fetch_rsp_inst;
		end
	end

	assign funct3 = ir.r_fmt.funct3;
	assign funct7 = ir.r_fmt.funct7;
	assign rs1    = ir.r_fmt.rs1[`REG_AW-1:0];
	assign rs2    = ir.r_fmt.rs2[`REG_AW-1:0];
	assign rd     = ir.r_fmt.rd[`REG_AW-1:0];

	// **************************************************
	// immediates by format.
	// **************************************************

	assign imm_i = {{(`XLEN-12){ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
	assign imm_s = {{(`XLEN-12){ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
	assign imm_b = {{(`XLEN-12){ir.b_fmt.imm12}}, ir.b_fmt.imm11, ir.b_fmt.imm10_5,
		ir.b_fmt.imm4_1, 1'b0};
	assign imm_u = {ir.u_fmt.imm, 12'b0};
	assign imm_j = {{(`XLEN-20){ir.j_fmt.imm20}}, ir.j_fmt.imm19_12, ir.j_fmt.imm11,
		ir.j_fmt.imm10_1, 1'b0};

	always_comb begin
		alu_op    = ADD;
		br_cond   = NONE;
		a_sel     = A_RS1;
		b_sel     = B_RS2;
		imm       = imm_s;
		jump      = 1'b0;
		jalr      = 1'b0;
		wb_pc4    = 1'b0;
		writes_rd = 1'b0;
		uses_rs1  = 1'b0;
		uses_rs2  = 1'b0;
		bad_op    = 1'b0;
		case (ir.r_fmt.opcode)
			OP: begin
				writes_rd = 1'b1;
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				alu_op    = alu_from_funct(funct3, funct7[5]);
				// only ADD/SUB and SRL/SRA have an alternate encoding.
				bad_op = !(funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			OP_IMM: begin
				writes_rd = 1'b1;
				uses_rs1  = 1'b1;
				imm       = imm_i;
				b_sel     = B_IMM;
				alu_op    = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001) begin
					bad_op = (funct7 != 7'b0000000);
				end else if (funct3 == 3'b101) begin
					bad_op = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
				end
			end
			LUI: begin
				writes_rd = 1'b1;
				imm       = imm_u;
				b_sel     = B_IMM;
				alu_op    = PASS_B;
			end
			AUIPC: begin
				writes_rd = 1'b1;
				imm       = imm_u;
				a_sel     = A_PC;
				b_sel     = B_IMM;
			end
			JAL: begin
				writes_rd = 1'b1;
				imm       = imm_j;
				jump      = 1'b1;
				wb_pc4    = 1'b1;
			end
			JALR: begin
				writes_rd = 1'b1;
				uses_rs1  = 1'b1;
				imm       = imm_i;
				jalr      = 1'b1;
				wb_pc4    = 1'b1;
				bad_op    = (funct3 != 3'b000);
			end
			BRANCH: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				imm      = imm_b;
				case (funct3)
					3'b000:  br_cond = BEQ;
					3'b001:  br_cond = BNE;
					3'b100:  br_cond = BLT;
					3'b101:  br_cond = BGE;
					3'b110:  br_cond = BLTU;
					3'b111:  br_cond = BGEU;
					default: bad_op  = 1'b1;
				endcase
			end
			default: begin
				bad_op = 1'b1;
			end
		endcase
	end

	// RV32E has no x16 and up.
	assign bad_reg = (uses_rs1 && ir.r_fmt.rs1 >= 5'(`REG_COUNT)) ||
		(uses_rs2 && ir.r_fmt.rs2 >= 5'(`REG_COUNT)) ||
		(writes_rd && ir.r_fmt.rd >= 5'(`REG_COUNT));

	assign illegal = bad_op || bad_reg;

endmodule

/* hw/alu.sv */
`include "rv_defs.svh"

module alu import core_pkg::*; (
	input  logic [`XLEN-1:0] a,
	input  logic [`XLEN-1:0] b,
	input  alu_op_e          alu_op,
	input  br_cond_e         br_cond,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	output logic [`XLEN-1:0] result,
	output logic             taken
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (alu_op)
			ADD:     result = a + b;
			SUB:     result = a - b;
			SLL:     result = a << shamt;
			SLT:     result = `XLEN'($signed(a) < $signed(b));
			SLTU:    result = `XLEN'(a < b);
			XOR:     result = a ^ b;
			SRL:     result = a >> shamt;
			SRA:     result = $signed(a) >>> shamt;
			OR:      result = a | b;
			AND:     result = a & b;
			PASS_B:  result = b;
			default: result = '0;
		endcase
	end

	// branch compare works on the register values, not the operands.
	always_comb begin
		case (br_cond)
			BEQ:     taken = (rs1_data == rs2_data);
			BNE:     taken = (rs1_data != rs2_data);
			BLT:     taken = ($signed(rs1_data) < $signed(rs2_data));
			BGE:     taken = ($signed(rs1_data) >= $signed(rs2_data));
			BLTU:    taken = (rs1_data < rs2_data);
			BGEU:    taken = (rs1_data >= rs2_data);
			default: taken = 1'b0;
		endcase
	end

endmodule

/* hw/regfile.sv */
`include "rv_defs.svh"

module regfile (
	input  logic               clock,
	input  logic               rst,
	input  logic               we,
	input  logic [`REG_AW-1:0] waddr,
	input  logic [`XLEN-1:0]   wdata,
	input  logic [`REG_AW-1:0] raddr1,
	input  logic [`REG_AW-1:0] raddr2,
	output logic [`XLEN-1:0]   rdata1,
	output logic [`XLEN-1:0]   rdata2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is hardwired.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* common/core_pkg.sv */
package core_pkg;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASS_B
	} alu_op_e;

	// NONE means the instruction is not a branch.
	typedef enum logic [2:0] {
		NONE,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU
	} br_cond_e;

	typedef enum logic [1:0] {
		FETCH = 2'd0,
		WAIT  = 2'd1,
		EXEC  = 2'd2,
		TRAP  = 2'd3
	} ctrl_state_e;

	// operand a select.
	localparam logic A_RS1 = 1'b0;
	localparam logic A_PC  = 1'b1;

	// operand b select.
	localparam logic B_RS2 = 1'b0;
	localparam logic B_IMM = 1'b1;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

	// major opcodes handled by the core.
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011
	} rv_opcode_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		rv_opcode_e opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		rv_opcode_e  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		rv_opcode_e opcode;
	} s_fmt_t;

	// branch offset bits are scattered across the word.
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		rv_opcode_e opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		rv_opcode_e  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		rv_opcode_e opcode;
	} j_fmt_t;

	// one instruction word, viewed in every format.
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} rv_inst_u;

endpackage

/* common/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// **************************************************
// core dimensions.
// **************************************************

// data and address width.
`define XLEN 32

// RV32E has sixteen integer registers.
`define REG_COUNT 16

// register index width.
`define REG_AW $clog2(`REG_COUNT)

// first fetch address after reset.
`define RESET_PC 32'h0000_0000

// **************************************************
// fetch port flow control.
// **************************************************

// most credits the core can hold at once.
`define CREDIT_MAX 4

`endif
